// ==== design/lease_cache_pkg.sv ====
`default_nettype none

package lease_cache_pkg;

	// widths
	// ----------------------------------------
	localparam int ADDR_W     = 16;                  // word address, not byte
	localparam int WORD_W     = 32;
	localparam int BLOCK_W    = 2;                   // 4 words per block
	localparam int TAG_W      = ADDR_W - BLOCK_W;    // fully associative, no index bits
	localparam int LEASE_W    = 8;
	localparam int LINE_IDX_W = 8;                   // line field of line_wr_t, up to 256 lines

	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [LEASE_W-1:0] lease_t;
	typedef logic [BLOCK_W-1:0] off_t;               // word offset in a block

	localparam lease_t DEFAULT_LEASE = lease_t'(2);  // lease on a table miss

	// index width for a table or line count, at least one bit
	function automatic int idx_w(input int entries);
		return (entries > 1) ? $clog2(entries) : 1;
	endfunction

	// encodings
	// ----------------------------------------
	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,  // wait for a core request
		ST_LOOKUP   = 3'd1,  // tag compare, lease lookup
		ST_VICTIM   = 3'd2,  // pick line, install tag, start engines
		ST_TRANSFER = 3'd3,  // writeback and refill in flight
		ST_REPLAY   = 3'd4,  // serve the request from the new line
		ST_BYPASS   = 3'd5   // zero lease, single uncached word
	} ctrl_state_e;

	// bundles
	// ----------------------------------------
	typedef struct packed {
		logic  rw;    // 1 = store
		addr_t addr;
		word_t data;
	} core_req_t;

	typedef struct packed {
		word_t data;
		logic  hit;
	} core_rsp_t;

	typedef struct packed {
		tag_t   tag;
		lease_t lease;
	} llt_wr_t;

	typedef struct packed {
		mem_op_e op;
		addr_t   addr;
		word_t   data;
	} mem_cmd_t;

	typedef struct packed {
		logic [LINE_IDX_W-1:0] line;  // low bits used
		off_t                  off;
		word_t                 data;
	} line_wr_t;

endpackage

`default_nettype wire

// ==== design/tag_store.sv ====
`default_nettype none

module tag_store import lease_cache_pkg::*; #(
	parameter int LINES = 4
)(
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  tag_t                   lookup_tag_i,
	output logic                   hit_o,
	output logic [idx_w(LINES)-1:0] hit_line_o,
	input  logic                   wr_i,          // install wr_tag_i into wr_line_i
	input  logic [idx_w(LINES)-1:0] wr_line_i,
	input  tag_t                   wr_tag_i,
	input  logic                   set_dirty_i,   // store hit on wr_line_i
	input  logic                   clr_dirty_i,
	input  logic [idx_w(LINES)-1:0] line_i,        // victim probe
	output logic [LINES-1:0]       valid_o,
	output logic                   dirty_o,
	output tag_t                   tag_o
);

	localparam int LW = idx_w(LINES);

	tag_t             tag_q [LINES];
	logic [LINES-1:0] valid_q;
	logic [LINES-1:0] dirty_q;

	// parallel compare, at most one line matches
	always_comb begin
		hit_o      = 1'b0;
		hit_line_o = '0;
		for (int i = 0; i < LINES; i++) begin
			if (valid_q[i] && (tag_q[i] == lookup_tag_i)) begin
				hit_o      = 1'b1;
				hit_line_o = LW'(i);
			end
		end
	end

	assign valid_o = valid_q;              // whole vector for victim choice
	assign dirty_o = dirty_q[line_i];
	assign tag_o   = tag_q[line_i];        // old tag, builds writeback address

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (wr_i)
				valid_q[wr_line_i] <= 1'b1;
			if (clr_dirty_i)
				dirty_q[wr_line_i] <= 1'b0;  // fresh line is clean
			else if (set_dirty_i)
				dirty_q[wr_line_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (wr_i)
			tag_q[wr_line_i] <= wr_tag_i;
	end

endmodule

`default_nettype wire

// ==== design/lease_table.sv ====
`default_nettype none

module lease_table import lease_cache_pkg::*; #(
	parameter int LINES       = 4,
	parameter int LLT_ENTRIES = 8
)(
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  logic                    llt_wr_valid_i,
	input  llt_wr_t                 llt_wr_i,
	input  tag_t                    lookup_tag_i,
	output lease_t                  lease_o,
	input  logic                    access_i,      // one per core reference
	input  logic                    renew_i,
	input  logic [idx_w(LINES)-1:0] renew_line_i,
	input  lease_t                  renew_lease_i,
	input  logic [LINES-1:0]        valid_i,
	output logic [idx_w(LINES)-1:0] victim_o
);

	localparam int LW = idx_w(LINES);
	localparam int EW = idx_w(LLT_ENTRIES);

	// lookup table
	// ----------------------------------------
	tag_t                   llt_tag_q   [LLT_ENTRIES];
	lease_t                 llt_lease_q [LLT_ENTRIES];
	logic [LLT_ENTRIES-1:0] llt_vld_q;              // entry written since reset

	logic [EW-1:0] wr_idx;
	logic [EW-1:0] lk_idx;

	assign wr_idx = llt_wr_i.tag[EW-1:0];          // direct mapped on low tag bits
	assign lk_idx = lookup_tag_i[EW-1:0];

	assign lease_o = (llt_vld_q[lk_idx] && (llt_tag_q[lk_idx] == lookup_tag_i)) ?
		llt_lease_q[lk_idx] : DEFAULT_LEASE;

	always_ff @(posedge clock_i) begin
		if (llt_wr_valid_i) begin
			llt_tag_q[wr_idx]   <= llt_wr_i.tag;
			llt_lease_q[wr_idx] <= llt_wr_i.lease;
		end
	end

	// per-line lease counters
	// ----------------------------------------
	lease_t cnt_q [LINES];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			llt_vld_q <= '0;
			for (int i = 0; i < LINES; i++)
				cnt_q[i] <= '0;
		end else begin
			if (llt_wr_valid_i)
				llt_vld_q[wr_idx] <= 1'b1;
			for (int i = 0; i < LINES; i++) begin
				if (renew_i && (renew_line_i == LW'(i)))
					cnt_q[i] <= renew_lease_i;         // renew wins over the decrement
				else if (access_i && (cnt_q[i] != '0))
					cnt_q[i] <= cnt_q[i] - 1'b1;       // saturate at zero
			end
		end
	end

	// victim choice
	// ----------------------------------------
	logic          inv_found;
	logic [LW-1:0] inv_line;
	logic [LW-1:0] min_line;
	lease_t        min_lease;

	// strict less-than keeps the lowest index on ties, so an expired
	// line always wins the minimum search when one exists
	always_comb begin
		inv_found = 1'b0;
		inv_line  = '0;
		min_line  = '0;
		min_lease = cnt_q[0];
		for (int i = 0; i < LINES; i++) begin
			if (!valid_i[i] && !inv_found) begin
				inv_found = 1'b1;
				inv_line  = LW'(i);
			end
			if (cnt_q[i] < min_lease) begin
				min_lease = cnt_q[i];
				min_line  = LW'(i);
			end
		end
		victim_o = inv_found ? inv_line : min_line;
	end

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
`default_nettype none

module cache_ctrl import lease_cache_pkg::*; #(
	parameter int LINES       = 4,
	parameter int LLT_ENTRIES = 8
)(
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  logic                    core_req_valid_i,
	input  core_req_t               core_req_i,
	output logic                    core_done_o,
	output core_rsp_t               core_rsp_o,
	input  logic                    llt_wr_valid_i,
	input  llt_wr_t                 llt_wr_i,
	output logic                    miss_start_o,
	output logic                    miss_block_o,   // 0 = single uncached word
	output core_req_t               miss_req_o,
	input  logic                    miss_done_i,
	output logic                    wb_start_o,
	output logic [idx_w(LINES)-1:0] wb_line_o,      // victim, also the fill line
	output tag_t                    wb_tag_o,
	input  logic                    wb_done_i,
	input  logic                    fill_wr_valid_i,
	input  line_wr_t                fill_wr_i,
	input  logic [idx_w(LINES)-1:0] wb_rd_line_i,
	input  off_t                    wb_rd_off_i,
	output word_t                   wb_rd_data_o,
	input  word_t                   bypass_data_i
);

	localparam int LW = idx_w(LINES);

	ctrl_state_e   state_q;
	core_req_t     req_q;
	core_rsp_t     rsp_q;
	logic          done_q, miss_start_q, miss_block_q, wb_start_q;
	logic          wb_busy_q;                    // writeback still streaming
	logic [LW-1:0] victim_q;
	tag_t          wb_tag_q;
	word_t         data_mem [LINES << BLOCK_W];  // {line, offset}

	tag_t             req_tag;
	off_t             req_off;
	logic             hit, victim_dirty, hit_serve, tag_wr;
	logic [LW-1:0]    hit_line, victim, wr_line;
	logic [LINES-1:0] valid_vec;
	tag_t             victim_tag;
	lease_t           lease;
	word_t            hit_word;

	assign req_tag   = req_q.addr[ADDR_W-1:BLOCK_W];
	assign req_off   = req_q.addr[BLOCK_W-1:0];
	assign hit_serve = hit && ((state_q == ST_LOOKUP) || (state_q == ST_REPLAY));
	assign tag_wr    = (state_q == ST_VICTIM);
	assign wr_line   = tag_wr ? victim : hit_line;
	assign hit_word  = data_mem[{hit_line, req_off}];

	tag_store #(.LINES(LINES)) u_tags (
		.clock_i, .resetn_i,
		.lookup_tag_i (req_tag),
		.hit_o        (hit),
		.hit_line_o   (hit_line),
		.wr_i         (tag_wr),
		.wr_line_i    (wr_line),
		.wr_tag_i     (req_tag),
		.set_dirty_i  (hit_serve && req_q.rw),
		.clr_dirty_i  (tag_wr),
		.line_i       (victim),
		.valid_o      (valid_vec),
		.dirty_o      (victim_dirty),
		.tag_o        (victim_tag)
	);

	// decrement on the first lookup only, a replay is the same reference
	lease_table #(.LINES(LINES), .LLT_ENTRIES(LLT_ENTRIES)) u_leases (
		.clock_i, .resetn_i, .llt_wr_valid_i, .llt_wr_i,
		.lookup_tag_i  (req_tag),
		.lease_o       (lease),
		.access_i      (state_q == ST_LOOKUP),
		.renew_i       (((state_q == ST_LOOKUP) && hit) || tag_wr),
		.renew_line_i  (wr_line),
		.renew_lease_i (lease),
		.valid_i       (valid_vec),
		.victim_o      (victim)
	);

	// data array, fill and store never overlap
	always_ff @(posedge clock_i) begin
		if (fill_wr_valid_i)
			data_mem[{fill_wr_i.line[LW-1:0], fill_wr_i.off}] <= fill_wr_i.data;
		else if (hit_serve && req_q.rw)
			data_mem[{hit_line, req_off}] <= req_q.data;
	end

	assign wb_rd_data_o = data_mem[{wb_rd_line_i, wb_rd_off_i}];

	// sequencing
	// ----------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q      <= ST_IDLE;
			done_q       <= 1'b0;
			miss_start_q <= 1'b0;
			miss_block_q <= 1'b0;
			wb_start_q   <= 1'b0;
			wb_busy_q    <= 1'b0;
		end else begin
			done_q       <= 1'b0;    // strobes
			miss_start_q <= 1'b0;
			wb_start_q   <= 1'b0;
			if (wb_done_i)
				wb_busy_q <= 1'b0;
			case (state_q)
				ST_IDLE: if (core_req_valid_i) state_q <= ST_LOOKUP;
				ST_LOOKUP: begin
					if (hit) begin
						done_q  <= 1'b1;
						state_q <= ST_IDLE;
					end else if (lease == '0) begin     // not worth caching
						miss_start_q <= 1'b1;
						miss_block_q <= 1'b0;
						state_q      <= ST_BYPASS;
					end else
						state_q <= ST_VICTIM;
				end
				ST_VICTIM: begin
					miss_start_q <= 1'b1;
					miss_block_q <= 1'b1;
					wb_start_q   <= victim_dirty;
					wb_busy_q    <= victim_dirty;
					state_q      <= ST_TRANSFER;
				end
				ST_TRANSFER: begin
					if (miss_done_i && (!wb_busy_q || wb_done_i))
						state_q <= ST_REPLAY;
				end
				ST_REPLAY: begin
					done_q  <= 1'b1;
					state_q <= ST_IDLE;
				end
				ST_BYPASS: begin
					if (miss_done_i) begin
						done_q  <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// request, victim and response capture
	always_ff @(posedge clock_i) begin
		if ((state_q == ST_IDLE) && core_req_valid_i)
			req_q <= core_req_i;
		if (tag_wr) begin
			victim_q <= victim;
			wb_tag_q <= victim_tag;    // read before the new tag lands
		end
		if (hit_serve)
			rsp_q <= '{data: hit_word, hit: (state_q == ST_LOOKUP)};
		else if ((state_q == ST_BYPASS) && miss_done_i)
			rsp_q <= '{data: bypass_data_i, hit: 1'b0};
	end

	assign core_done_o  = done_q;
	assign core_rsp_o   = rsp_q;
	assign miss_start_o = miss_start_q;
	assign miss_block_o = miss_block_q;
	assign miss_req_o   = req_q;
	assign wb_start_o   = wb_start_q;
	assign wb_line_o    = victim_q;
	assign wb_tag_o     = wb_tag_q;

endmodule

`default_nettype wire

// ==== design/miss_engine.sv ====
`default_nettype none

module miss_engine import lease_cache_pkg::*; #(
	parameter int LINES = 4
)(
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  logic                    start_i,
	input  logic                    block_i,          // 1 = refill, 0 = single word
	input  core_req_t               req_i,
	output logic                    req_o,
	output mem_cmd_t                cmd_o,
	input  logic                    grant_i,
	input  logic                    mem_rsp_valid_i,
	input  word_t                   mem_rsp_data_i,
	input  logic [idx_w(LINES)-1:0] fill_line_i,
	output logic                    fill_wr_valid_o,
	output line_wr_t                fill_wr_o,
	output word_t                   bypass_data_o,
	output logic                    done_o
);

	localparam logic [BLOCK_W:0] BLK_WORDS = 1 << BLOCK_W;

	logic             busy_q, block_q, done_q;
	logic [BLOCK_W:0] iss_q;                  // commands granted
	logic [BLOCK_W:0] rsp_q;                  // responses seen
	core_req_t        req_q;
	word_t            byp_q;
	logic [BLOCK_W:0] n_words;
	logic             single_wr;

	assign n_words   = block_q ? BLK_WORDS : (BLOCK_W+1)'(1);
	assign single_wr = !block_q && req_q.rw;  // refills always read
	assign req_o     = busy_q && (iss_q != n_words);  // held until granted

	always_comb begin
		cmd_o.op   = single_wr ? MEM_WRITE : MEM_READ;
		cmd_o.addr = block_q ? {req_q.addr[ADDR_W-1:BLOCK_W], iss_q[BLOCK_W-1:0]} : req_q.addr;
		cmd_o.data = req_q.data;
	end

	// responses come back in order, offset = response count
	assign fill_wr_valid_o = busy_q && block_q && mem_rsp_valid_i;
	assign fill_wr_o       = '{line: LINE_IDX_W'(fill_line_i), off: rsp_q[BLOCK_W-1:0],
		data: mem_rsp_data_i};

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			busy_q  <= 1'b0;
			block_q <= 1'b0;
			done_q  <= 1'b0;
			iss_q   <= '0;
			rsp_q   <= '0;
		end else begin
			done_q <= 1'b0;
			if (start_i) begin
				busy_q  <= 1'b1;
				block_q <= block_i;
				iss_q   <= '0;
				rsp_q   <= '0;
			end else if (busy_q) begin
				if (grant_i) begin
					iss_q <= iss_q + 1'b1;
					if (single_wr) begin        // no response for a write
						busy_q <= 1'b0;
						done_q <= 1'b1;
					end
				end
				if (mem_rsp_valid_i) begin
					rsp_q <= rsp_q + 1'b1;
					if (rsp_q == n_words - 1'b1) begin
						busy_q <= 1'b0;
						done_q <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (start_i)
			req_q <= req_i;
		if (busy_q && !block_q && mem_rsp_valid_i)
			byp_q <= mem_rsp_data_i;            // uncached load word
	end

	assign bypass_data_o = byp_q;
	assign done_o        = done_q;

endmodule

`default_nettype wire

// ==== design/writeback_engine.sv ====
`default_nettype none

module writeback_engine import lease_cache_pkg::*; #(
	parameter int LINES = 4
)(
	input  logic                    clock_i,
	input  logic                    resetn_i,
	input  logic                    start_i,
	input  logic [idx_w(LINES)-1:0] line_i,
	input  tag_t                    tag_i,
	output logic [idx_w(LINES)-1:0] rd_line_o,
	output off_t                    rd_off_o,
	input  word_t                   rd_data_i,     // same-cycle array read
	output logic                    req_o,
	output mem_cmd_t                cmd_o,
	input  logic                    grant_i,
	output logic                    done_o
);

	localparam int LW = idx_w(LINES);

	logic          busy_q, done_q;
	off_t          off_q;
	logic [LW-1:0] line_q;
	tag_t          tag_q;

	assign req_o     = busy_q;       // top priority, granted every cycle
	assign rd_line_o = line_q;
	assign rd_off_o  = off_q;
	assign cmd_o     = '{op: MEM_WRITE, addr: {tag_q, off_q}, data: rd_data_i};
	assign done_o    = done_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			off_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (start_i) begin
				busy_q <= 1'b1;
				off_q  <= '0;
			end else if (busy_q && grant_i) begin
				off_q <= off_q + 1'b1;
				if (off_q == '1) begin       // last word of the block
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (start_i) begin
			line_q <= line_i;
			tag_q  <= tag_i;
		end
	end

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter import lease_cache_pkg::*; (
	input  logic     clock_i,
	input  logic     resetn_i,
	input  logic     wb_req_i,
	input  mem_cmd_t wb_cmd_i,
	output logic     wb_grant_o,
	input  logic     miss_req_i,
	input  mem_cmd_t miss_cmd_i,
	output logic     miss_grant_o,
	output logic     mem_cmd_valid_o,
	output mem_cmd_t mem_cmd_o
);

	logic     valid_q;
	mem_cmd_t cmd_q;

	// fixed priority, dirty data leaves before the refill reads go out
	assign wb_grant_o   = wb_req_i;
	assign miss_grant_o = miss_req_i && !wb_req_i;

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			valid_q <= 1'b0;
		else
			valid_q <= wb_req_i || miss_req_i;   // one cycle behind the grant
	end

	always_ff @(posedge clock_i) begin
		cmd_q <= wb_req_i ? wb_cmd_i : miss_cmd_i;
	end

	assign mem_cmd_valid_o = valid_q;
	assign mem_cmd_o       = cmd_q;

endmodule

`default_nettype wire

// ==== design/lease_cache_top.sv ====
`default_nettype none

module lease_cache_top import lease_cache_pkg::*; #(
	parameter int LINES       = 4,
	parameter int LLT_ENTRIES = 8
)(
	input  logic      clock_i,
	input  logic      resetn_i,
	input  logic      core_req_valid_i,
	input  core_req_t core_req_i,
	output logic      core_done_o,
	output core_rsp_t core_rsp_o,
	input  logic      llt_wr_valid_i,
	input  llt_wr_t   llt_wr_i,
	output logic      mem_cmd_valid_o,
	output mem_cmd_t  mem_cmd_o,
	input  logic      mem_rsp_valid_i,
	input  word_t     mem_rsp_data_i
);

	localparam int LW = idx_w(LINES);

	// controller to engines
	logic          miss_start, miss_block, miss_done;
	logic          wb_start, wb_done;
	core_req_t     miss_req;
	logic [LW-1:0] victim_line;    // writeback source and refill target
	tag_t          wb_tag;

	// data array ports
	logic          fill_wr_valid;
	line_wr_t      fill_wr;
	logic [LW-1:0] wb_rd_line;
	off_t          wb_rd_off;
	word_t         wb_rd_data, bypass_data;

	// arbiter side
	logic          wb_req, miss_req_cmd, wb_grant, miss_grant;
	mem_cmd_t      wb_cmd, miss_cmd;

	cache_ctrl #(.LINES(LINES), .LLT_ENTRIES(LLT_ENTRIES)) u_ctrl (
		.clock_i, .resetn_i, .core_req_valid_i, .core_req_i, .core_done_o, .core_rsp_o,
		.llt_wr_valid_i, .llt_wr_i,
		.miss_start_o    (miss_start),
		.miss_block_o    (miss_block),
		.miss_req_o      (miss_req),
		.miss_done_i     (miss_done),
		.wb_start_o      (wb_start),
		.wb_line_o       (victim_line),
		.wb_tag_o        (wb_tag),
		.wb_done_i       (wb_done),
		.fill_wr_valid_i (fill_wr_valid),
		.fill_wr_i       (fill_wr),
		.wb_rd_line_i    (wb_rd_line),
		.wb_rd_off_i     (wb_rd_off),
		.wb_rd_data_o    (wb_rd_data),
		.bypass_data_i   (bypass_data)
	);

	miss_engine #(.LINES(LINES)) u_miss (
		.clock_i, .resetn_i, .mem_rsp_valid_i, .mem_rsp_data_i,
		.start_i         (miss_start),
		.block_i         (miss_block),
		.req_i           (miss_req),
		.req_o           (miss_req_cmd),
		.cmd_o           (miss_cmd),
		.grant_i         (miss_grant),
		.fill_line_i     (victim_line),
		.fill_wr_valid_o (fill_wr_valid),
		.fill_wr_o       (fill_wr),
		.bypass_data_o   (bypass_data),
		.done_o          (miss_done)
	);

	writeback_engine #(.LINES(LINES)) u_wb (
		.clock_i, .resetn_i,
		.start_i   (wb_start),
		.line_i    (victim_line),
		.tag_i     (wb_tag),
		.rd_line_o (wb_rd_line),
		.rd_off_o  (wb_rd_off),
		.rd_data_i (wb_rd_data),
		.req_o     (wb_req),
		.cmd_o     (wb_cmd),
		.grant_i   (wb_grant),
		.done_o    (wb_done)
	);

	mem_arbiter u_arb (
		.clock_i, .resetn_i, .mem_cmd_valid_o, .mem_cmd_o,
		.wb_req_i     (wb_req),
		.wb_cmd_i     (wb_cmd),
		.wb_grant_o   (wb_grant),
		.miss_req_i   (miss_req_cmd),
		.miss_cmd_i   (miss_cmd),
		.miss_grant_o (miss_grant)
	);

endmodule

`default_nettype wire

// ==== test/mem_model.sv ====
`default_nettype none

module mem_model import lease_cache_pkg::*; #(
	parameter int unsigned SEED = 13818
)(
	input  logic     clock_i,
	input  logic     mem_cmd_valid_i,
	input  mem_cmd_t mem_cmd_i,
	output logic     mem_rsp_valid_o,
	output word_t    mem_rsp_data_o
);

	timeunit 1ns;
	timeprecision 100ps;

	word_t       mem [1 << ADDR_W];
	word_t       rsp_data_q [$];      // read data, in command order
	int unsigned rsp_due_q [$];       // cycle each response goes out
	int unsigned cycle;
	int unsigned last_due;
	int unsigned due;
	logic [31:0] lcg_state;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// every word differs, all 16 address bits show up in the data
	function automatic word_t fill_word(input addr_t a);
		return {a ^ 16'hc35a, ~a};
	endfunction

	initial begin
		mem_rsp_valid_o = 1'b0;
		mem_rsp_data_o  = '0;
		cycle           = 0;
		last_due        = 0;
		lcg_state       = SEED;
		for (int a = 0; a < (1 << ADDR_W); a++)
			mem[a] = fill_word(addr_t'(a));
		forever begin
			@(posedge clock_i);
			#1;                                   // outputs of this edge are settled
			cycle++;
			if (mem_cmd_valid_i) begin
				if (mem_cmd_i.op == MEM_WRITE) begin
					mem[mem_cmd_i.addr] = mem_cmd_i.data;
				end else begin
					lcg_state = lcg_next(lcg_state);
					due = cycle + 1 + int'(lcg_state[25:24]);  // 1 to 4 cycles
					if (due <= last_due)
						due = last_due + 1;               // keep order, one strobe per cycle
					last_due = due;
					rsp_due_q.push_back(due);
					rsp_data_q.push_back(mem[mem_cmd_i.addr]);
				end
			end
			mem_rsp_valid_o = 1'b0;
			if ((rsp_due_q.size() > 0) && (rsp_due_q[0] == cycle)) begin
				mem_rsp_valid_o = 1'b1;
				mem_rsp_data_o  = rsp_data_q.pop_front();
				void'(rsp_due_q.pop_front());
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_top.sv ====
`default_nettype none

module tb_top import lease_cache_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINES       = 4;
	localparam int LLT_ENTRIES = 8;
	localparam int TIMEOUT     = 200;   // cycles per wait
	localparam int N_RANDOM    = 80;

	logic      clock, resetn;
	logic      core_req_valid, core_done;
	core_req_t core_req;
	core_rsp_t core_rsp;
	logic      llt_wr_valid;
	llt_wr_t   llt_wr;
	logic      mem_cmd_valid, mem_rsp_valid;
	mem_cmd_t  mem_cmd;
	word_t     mem_rsp_data;

	// reference model
	// ----------------------------------------
	tag_t   m_tag   [LINES];
	logic   m_valid [LINES];
	logic   m_dirty [LINES];
	lease_t m_lease [LINES];
	word_t  m_data  [LINES][4];
	tag_t   t_tag   [LLT_ENTRIES];    // lease table copy
	lease_t t_lease [LLT_ENTRIES];
	logic   t_vld   [LLT_ENTRIES];
	word_t  ref_mem [addr_t];         // words written so far, rest is fill

	logic        exp_hit, exp_rd, req_busy;
	word_t       exp_data;
	mem_cmd_t    exp_cmds [$];
	mem_cmd_t    got_cmds [$];
	int          n_hits, n_bypass, n_dirty_evict;
	logic [31:0] rng;

	lease_cache_top #(.LINES(LINES), .LLT_ENTRIES(LLT_ENTRIES)) dut (
		.clock_i          (clock),
		.resetn_i         (resetn),
		.core_req_valid_i (core_req_valid),
		.core_req_i       (core_req),
		.core_done_o      (core_done),
		.core_rsp_o       (core_rsp),
		.llt_wr_valid_i   (llt_wr_valid),
		.llt_wr_i         (llt_wr),
		.mem_cmd_valid_o  (mem_cmd_valid),
		.mem_cmd_o        (mem_cmd),
		.mem_rsp_valid_i  (mem_rsp_valid),
		.mem_rsp_data_i   (mem_rsp_data)
	);

	mem_model #(.SEED(13818)) u_mem (
		.clock_i         (clock),
		.mem_cmd_valid_i (mem_cmd_valid),
		.mem_cmd_i       (mem_cmd),
		.mem_rsp_valid_o (mem_rsp_valid),
		.mem_rsp_data_o  (mem_rsp_data)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;   // 4 ns period
	end

	always @(negedge clock) begin
		if (mem_cmd_valid)
			got_cmds.push_back(mem_cmd);
	end

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// port checks
	// ----------------------------------------
	a_done_pending: assert property (@(posedge clock) disable iff (!resetn)
		core_done |-> req_busy)
		else begin
			$display("core_done_o pulsed with no request outstanding");
			abort_run();
		end

	a_cmd_pending: assert property (@(posedge clock) disable iff (!resetn)
		mem_cmd_valid |-> req_busy)
		else begin
			$display("memory command issued with no request outstanding");
			abort_run();
		end

	a_hit_flag: assert property (@(posedge clock) disable iff (!resetn)
		core_done |-> (core_rsp.hit == exp_hit))
		else begin
			$display("MISMATCH core_rsp_o.hit got %h exp %h", core_rsp.hit, exp_hit);
			abort_run();
		end

	a_rd_data: assert property (@(posedge clock) disable iff (!resetn)
		(core_done && exp_rd) |-> (core_rsp.data == exp_data))
		else begin
			$display("MISMATCH core_rsp_o.data got %h exp %h", core_rsp.data, exp_data);
			abort_run();
		end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got == exp) else begin
			$display("MISMATCH %s got %h exp %h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic word_t fill_word(input addr_t a);
		return {a ^ 16'hc35a, ~a};   // same fill as the memory model
	endfunction

	function automatic word_t mem_read(input addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	function automatic mem_cmd_t make_cmd(input mem_op_e op, input addr_t a, input word_t d);
		return '{op: op, addr: a, data: d};
	endfunction

	function automatic lease_t lookup_lease(input tag_t tag);
		int idx;
		idx = int'(tag) % LLT_ENTRIES;
		return (t_vld[idx] && (t_tag[idx] == tag)) ? t_lease[idx] : DEFAULT_LEASE;
	endfunction

	// invalid line first, then an expired one, then the shortest lease
	function automatic int pick_victim();
		int v;
		v = -1;
		for (int i = LINES - 1; i >= 0; i--)
			if (!m_valid[i])
				v = i;
		if (v < 0)
			for (int i = LINES - 1; i >= 0; i--)
				if (m_lease[i] == '0)
					v = i;
		if (v < 0) begin
			v = 0;
			for (int i = 1; i < LINES; i++)
				if (m_lease[i] < m_lease[v])
					v = i;   // strict, lowest index on a tie
		end
		return v;
	endfunction

	// expected response and memory traffic of one core access
	function automatic void predict(input logic rw, input addr_t a, input word_t d);
		tag_t   tag;
		off_t   off;
		lease_t lease;
		int     h;
		tag     = a[ADDR_W-1:BLOCK_W];
		off     = a[BLOCK_W-1:0];
		lease   = lookup_lease(tag);
		h       = -1;
		exp_hit = 1'b0;
		exp_rd  = !rw;
		exp_cmds.delete();
		for (int i = 0; i < LINES; i++)
			if (m_valid[i] && (m_tag[i] == tag))
				h = i;
		for (int i = 0; i < LINES; i++)
			if (m_lease[i] != '0)
				m_lease[i] = m_lease[i] - 1'b1;   // each reference ages all lines
		if (h >= 0) begin
			exp_hit    = 1'b1;
			m_lease[h] = lease;
			n_hits++;
		end else if (lease == '0) begin
			n_bypass++;                         // single uncached word, no fill
			if (rw) begin
				exp_cmds.push_back(make_cmd(MEM_WRITE, a, d));
				ref_mem[a] = d;
			end else begin
				exp_cmds.push_back(make_cmd(MEM_READ, a, '0));
				exp_data = mem_read(a);
			end
		end else begin
			h = pick_victim();
			if (m_valid[h] && m_dirty[h]) begin
				n_dirty_evict++;
				for (int k = 0; k < 4; k++) begin
					exp_cmds.push_back(make_cmd(MEM_WRITE, {m_tag[h], off_t'(k)}, m_data[h][k]));
					ref_mem[{m_tag[h], off_t'(k)}] = m_data[h][k];
				end
			end
			for (int k = 0; k < 4; k++) begin  // refill after the writeback
				exp_cmds.push_back(make_cmd(MEM_READ, {tag, off_t'(k)}, '0));
				m_data[h][k] = mem_read({tag, off_t'(k)});
			end
			m_tag[h]   = tag;
			m_valid[h] = 1'b1;
			m_dirty[h] = 1'b0;
			m_lease[h] = lease;
		end
		if (h >= 0) begin                     // hit or replay
			if (rw) begin
				m_data[h][off] = d;
				m_dirty[h]     = 1'b1;
			end else begin
				exp_data = m_data[h][off];
			end
		end
	endfunction

	// stimulus
	// ----------------------------------------
	task automatic write_lease(input tag_t tag, input lease_t lease);
		int idx;
		idx = int'(tag) % LLT_ENTRIES;
		@(posedge clock);
		#1;
		llt_wr_valid = 1'b1;
		llt_wr       = '{tag: tag, lease: lease};
		@(posedge clock);
		#1;
		llt_wr_valid = 1'b0;
		t_tag[idx]   = tag;
		t_lease[idx] = lease;
		t_vld[idx]   = 1'b1;
	endtask

	task automatic access(input logic rw, input addr_t a, input word_t d);
		int wait_cnt;
		predict(rw, a, d);
		got_cmds.delete();
		@(posedge clock);
		#1;
		core_req_valid = 1'b1;
		core_req       = '{rw: rw, addr: a, data: d};
		req_busy       = 1'b1;
		@(posedge clock);
		#1;
		core_req_valid = 1'b0;
		wait_cnt       = 0;
		do begin
			@(negedge clock);
			wait_cnt++;
			if (wait_cnt > TIMEOUT) begin
				$display("core_done_o did not arrive within %0d cycles", TIMEOUT);
				abort_run();
			end
		end while (!core_done);
		if (exp_hit)
			check_value("core_done_o latency", wait_cnt, 2);   // lookup, then response
		check_value("mem_cmd_valid_o count", got_cmds.size(), exp_cmds.size());
		for (int i = 0; i < exp_cmds.size(); i++) begin
			check_value("mem_cmd_o.op", got_cmds[i].op, exp_cmds[i].op);
			check_value("mem_cmd_o.addr", got_cmds[i].addr, exp_cmds[i].addr);
			if (exp_cmds[i].op == MEM_WRITE)
				check_value("mem_cmd_o.data", got_cmds[i].data, exp_cmds[i].data);
		end
		@(posedge clock);
		#1;
		req_busy = 1'b0;   // done has been sampled by the port checks
	endtask

	function automatic tag_t pool_tag(input logic [2:0] sel);
		case (sel)
			3'd1:    return 14'h011;
			3'd2:    return 14'h021;
			3'd3:    return 14'h032;
			3'd4:    return 14'h0a3;
			3'd5:    return 14'h0b4;
			3'd6:    return 14'h0c5;
			default: return 14'h010;   // zero lease
		endcase
	endfunction

	initial begin
		addr_t addr;
		word_t wdata;
		logic  rw;
		resetn         = 1'b0;
		core_req_valid = 1'b0;
		core_req       = '0;
		llt_wr_valid   = 1'b0;
		llt_wr         = '0;
		req_busy       = 1'b0;
		exp_hit        = 1'b0;
		exp_rd         = 1'b0;
		exp_data       = '0;
		n_hits         = 0;
		n_bypass       = 0;
		n_dirty_evict  = 0;
		rng            = 32'd13818;
		for (int i = 0; i < LINES; i++) begin
			m_valid[i] = 1'b0;
			m_dirty[i] = 1'b0;
			m_lease[i] = '0;
		end
		for (int i = 0; i < LLT_ENTRIES; i++)
			t_vld[i] = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		resetn = 1'b1;

		write_lease(14'h010, 8'd0);   // never cached
		write_lease(14'h021, 8'd9);
		write_lease(14'h032, 8'd5);
		write_lease(14'h0b4, 8'd1);

		access(1'b1, 16'h0045, 32'hdeadbeef);   // write miss
		access(1'b0, 16'h0045, '0);             // read back, hit
		access(1'b0, 16'h0086, '0);             // clean refill
		access(1'b0, 16'h0042, '0);             // uncached read
		access(1'b1, 16'h0042, 32'h600dcafe);   // uncached write
		access(1'b0, 16'h0042, '0);             // still a miss

		// random mix over a small tag pool, forces evictions
		for (int n = 0; n < N_RANDOM; n++) begin
			rng   = lcg_next(rng);
			addr  = {pool_tag(rng[30:28]), rng[21:20]};
			rw    = rng[24];
			rng   = lcg_next(rng);
			wdata = rng;
			access(rw, addr, wdata);
		end

		if ((n_hits > 0) && (n_bypass > 0) && (n_dirty_evict > 0)) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("stimulus missed a behavior, hits %0d bypass %0d dirty evictions %0d",
				n_hits, n_bypass, n_dirty_evict);
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
design/lease_cache_pkg.sv
design/tag_store.sv
design/lease_table.sv
design/cache_ctrl.sv
design/miss_engine.sv
design/writeback_engine.sv
design/mem_arbiter.sv
design/lease_cache_top.sv
test/mem_model.sv
test/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the lease cache testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
	--top-module tb_top -f tb.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "TEST RESULT: PASS" sim.log
echo "simulation finished without errors"
